//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = mant_unit_tb
FILELIST = filelist.f
OBJ_DIR  = obj_dir
SIM_BIN  = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST))
PASS_MSG = TESTS PASSED

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- filelist.f
hdl/mant_pkg.sv
hdl/mant_ctrl_fsm.sv
hdl/step_counter.sv
hdl/addsub_abs.sv
hdl/result_accumulator.sv
hdl/mant_unit_top.sv
verif/mant_unit_props.sv
verif/mant_unit_tb.sv

//--- hdl/addsub_abs.sv
/* Signed 25-bit add/subtract with a 26-bit result, split into sign and
   absolute magnitude. Purely combinational. */

`timescale 1ns/100ps
`default_nettype none

module addsub_abs (
	input  mant_pkg::opnd_t             opnd_a,
	input  mant_pkg::opnd_t             opnd_b,
	input  wire                         sub,
	output logic [mant_pkg::SUM_W-1:0] sum_mag,
	output logic                        sum_neg
);

	import mant_pkg::*;

	logic [SUM_W-1:0] ext_a;
	logic [SUM_W-1:0] ext_b;
	logic [SUM_W-1:0] b_inv;
	logic [SUM_W-1:0] sum;
	logic [SUM_W-1:0] sum_inv;

	//**********************************************************
	// Signed add or subtract
	//**********************************************************
	// One extra sign bit so the sum can never overflow
	assign ext_a = {opnd_a[OPND_W-1], opnd_a};
	assign ext_b = {opnd_b[OPND_W-1], opnd_b};

	// Subtract as a + ~b + 1
	assign b_inv = ext_b ^ {SUM_W{sub}};
	assign sum   = ext_a + b_inv + SUM_W'(sub);

	//**********************************************************
	// Absolute value
	//**********************************************************
	assign sum_neg = sum[SUM_W-1];

	// Invert and add one when negative, otherwise pass through
	assign sum_inv = sum ^ {SUM_W{sum_neg}};
	assign sum_mag = sum_inv + SUM_W'(sum_neg); // -2^25 maps to 2^25, still fits

endmodule

`default_nettype wire

//--- hdl/mant_ctrl_fsm.sv
/* Controller FSM for the mantissa unit. Accepts one req/ack request at a time
   and sequences the multiply steps or the single add/sub load. */

`timescale 1ns/100ps
`default_nettype none

module mant_ctrl_fsm (
	input  wire           clk,
	input  wire           arst_n,
	input  wire           req,
	input  mant_pkg::op_e op,
	input  wire           last,
	output logic          start,
	output logic          mul_en,
	output logic          load_sum,
	output logic          sub,
	output logic          ack
);

	import mant_pkg::*;

	state_e state_q;
	state_e state_d;
	logic   sub_q;
	logic   ack_q;

	//**********************************************************
	// Next state
	//**********************************************************
	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (req) begin
					// Anything that is not a multiply goes through the adder
					state_d = (op == OP_MUL) ? ST_MUL : ST_ADDSUB;
				end
			end
			ST_MUL: begin
				if (last) begin
					state_d = ST_DONE;     // Fourth partial product added this edge
				end
			end
			ST_ADDSUB: begin
				state_d = ST_DONE;
			end
			ST_DONE: begin
				if (!req) begin
					state_d = ST_IDLE;     // Requester released, close the handshake
				end
			end
			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

	//**********************************************************
	// State, subtract flag and ack registers
	//**********************************************************
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= ST_IDLE;
			sub_q   <= 1'b0;
			ack_q   <= 1'b0;
		end else begin
			state_q <= state_d;
			if (start) begin
				sub_q <= (op == OP_SUB);   // Op is only stable while req is high
			end
			// One cycle after the result settles, dropped once req is seen low
			ack_q <= (state_q == ST_DONE) && req;
		end
	end

	// Datapath strobes
	assign start    = (state_q == ST_IDLE) && req;
	assign mul_en   = (state_q == ST_MUL);
	assign load_sum = (state_q == ST_ADDSUB);

	assign sub = sub_q;
	assign ack = ack_q;

endmodule

`default_nettype wire

//--- hdl/mant_pkg.sv
/* Shared widths, vector types and enums for the mantissa arithmetic unit.
   Import into each module body that needs them. */

`default_nettype none

package mant_pkg;

	//**********************************************************
	// Widths
	//**********************************************************
	localparam int MANT_W  = 24;           // Single precision mantissa incl. hidden bit
	localparam int HALF_W  = 12;           // One half of a mantissa
	localparam int PROD_W  = 48;           // Full product
	localparam int OPND_W  = 25;           // Signed add/sub operand
	localparam int SUM_W   = 26;           // Signed sum, one guard bit
	localparam int N_STEPS = 4;            // Partial products per multiply
	localparam int STEP_W  = 2;            // Enough bits to index N_STEPS

	//**********************************************************
	// Vector types
	//**********************************************************
	typedef logic [OPND_W-1:0] opnd_t;
	typedef logic [PROD_W-1:0] prod_t;

	//**********************************************************
	// Encodings
	//**********************************************************
	// Request opcodes
	typedef enum logic [1:0] {
		OP_MUL = 2'd0,
		OP_ADD = 2'd1,
		OP_SUB = 2'd2
	} op_e;

	// Controller states
	typedef enum logic [1:0] {
		ST_IDLE   = 2'd0,
		ST_MUL    = 2'd1,                  // Four partial-product steps
		ST_ADDSUB = 2'd2,                  // Single add/sub load
		ST_DONE   = 2'd3                   // Result valid, waiting on req low
	} state_e;

endpackage

`default_nettype wire

//--- hdl/mant_unit_top.sv
/* Top level of the mantissa arithmetic unit. Connects controller, step
   counter, accumulator and add/sub block to the req/ack port set. */

`timescale 1ns/100ps
`default_nettype none

module mant_unit_top (
	input  wire             clk,
	input  wire             arst_n,
	input  wire             req,
	input  mant_pkg::op_e   op,
	input  mant_pkg::opnd_t a,
	input  mant_pkg::opnd_t b,
	output logic            ack,
	output mant_pkg::prod_t result,
	output logic            result_sign
);

	import mant_pkg::*;

	// Controller strobes
	logic              start;
	logic              mul_en;
	logic              load_sum;
	logic              sub;

	// Step sequencing
	logic [STEP_W-1:0] step;
	logic              last;

	// Datapath
	opnd_t             opnd_a_q;
	opnd_t             opnd_b_q;
	logic [SUM_W-1:0]  sum_mag;
	logic              sum_neg;

	//**********************************************************
	// Control
	//**********************************************************
	mant_ctrl_fsm u_mant_ctrl_fsm (
		.clk      (clk),
		.arst_n   (arst_n),
		.req      (req),
		.op       (op),
		.last     (last),
		.start    (start),
		.mul_en   (mul_en),
		.load_sum (load_sum),
		.sub      (sub),
		.ack      (ack)
	);

	step_counter u_step_counter (
		.clk    (clk),
		.arst_n (arst_n),
		.clear  (start),
		.en     (mul_en),
		.step   (step),
		.last   (last)
	);

	//**********************************************************
	// Datapath
	//**********************************************************
	result_accumulator u_result_accumulator (
		.clk         (clk),
		.arst_n      (arst_n),
		.start       (start),
		.mul_en      (mul_en),
		.load_sum    (load_sum),
		.step        (step),
		.a           (a),
		.b           (b),
		.sum_mag     (sum_mag),
		.sum_neg     (sum_neg),
		.opnd_a_q    (opnd_a_q),
		.result      (result),
		.opnd_b_q    (opnd_b_q),
		.result_sign (result_sign)
	);

	addsub_abs u_addsub_abs (
		.opnd_a  (opnd_a_q),                // Registered, stable through ST_ADDSUB
		.opnd_b  (opnd_b_q),
		.sub     (sub),
		.sum_mag (sum_mag),
		.sum_neg (sum_neg)
	);

endmodule

`default_nettype wire

//--- hdl/result_accumulator.sv
/* Operand and result registers. Builds the 48-bit product from four 12x12
   partial products, one per step, or loads the add/sub magnitude and sign. */

`timescale 1ns/100ps
`default_nettype none

module result_accumulator (
	input  wire                          clk,
	input  wire                          arst_n,
	input  wire                          start,
	input  wire                          mul_en,
	input  wire                          load_sum,
	input  wire  [mant_pkg::STEP_W-1:0] step,
	input  mant_pkg::opnd_t              a,
	input  mant_pkg::opnd_t              b,
	input  wire  [mant_pkg::SUM_W-1:0]  sum_mag,
	input  wire                          sum_neg,
	output mant_pkg::opnd_t              opnd_a_q,
	output mant_pkg::prod_t              result,
	output mant_pkg::opnd_t              opnd_b_q,
	output logic                         result_sign
);

	import mant_pkg::*;

	logic [HALF_W-1:0]   a_lo;
	logic [HALF_W-1:0]   a_hi;
	logic [HALF_W-1:0]   b_lo;
	logic [HALF_W-1:0]   b_hi;
	logic [HALF_W-1:0]   pp_x;
	logic [HALF_W-1:0]   pp_y;
	logic [2*HALF_W-1:0] pp;
	prod_t               pp_ext;
	prod_t               pp_shifted;
	prod_t               result_q;
	logic                sign_q;

	//**********************************************************
	// Operand registers
	//**********************************************************
	always_ff @(posedge clk) begin
		if (start) begin
			opnd_a_q <= a;
			opnd_b_q <= b;
		end
	end

	// Multiply uses the low 24 bits only, unsigned
	assign a_lo = opnd_a_q[HALF_W-1:0];
	assign a_hi = opnd_a_q[MANT_W-1:HALF_W];
	assign b_lo = opnd_b_q[HALF_W-1:0];
	assign b_hi = opnd_b_q[MANT_W-1:HALF_W];

	//**********************************************************
	// Partial product for the current step
	//**********************************************************
	always_comb begin
		case (step)
			2'd0: begin
				pp_x = a_lo;
				pp_y = b_lo;
			end
			2'd1: begin
				pp_x = a_hi;
				pp_y = b_lo;
			end
			2'd2: begin
				pp_x = a_lo;
				pp_y = b_hi;
			end
			default: begin
				pp_x = a_hi;
				pp_y = b_hi;
			end
		endcase
	end

	assign pp     = pp_x * pp_y;
	assign pp_ext = PROD_W'(pp);

	// Weight of the pair: lo.lo at 0, cross terms at 12, hi.hi at 24
	always_comb begin
		case (step)
			2'd0:    pp_shifted = pp_ext;
			2'd3:    pp_shifted = pp_ext << (2 * HALF_W);
			default: pp_shifted = pp_ext << HALF_W;
		endcase
	end

	//**********************************************************
	// Result register
	//**********************************************************
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			result_q <= '0;
			sign_q   <= 1'b0;
		end else if (start) begin
			result_q <= '0;
			sign_q   <= 1'b0;              // Stays 0 for a multiply
		end else if (mul_en) begin
			result_q <= result_q + pp_shifted;
		end else if (load_sum) begin
			result_q <= PROD_W'(sum_mag);  // Zero extended magnitude
			sign_q   <= sum_neg;
		end
	end

	assign result      = result_q;
	assign result_sign = sign_q;

endmodule

`default_nettype wire

//--- hdl/step_counter.sv
/* Step counter for the partial-product multiply. Cleared on acceptance,
   advanced once per enabled cycle, flags the final step. */

`timescale 1ns/100ps
`default_nettype none

module step_counter (
	input  wire                          clk,
	input  wire                          arst_n,
	input  wire                          clear,
	input  wire                          en,
	output logic [mant_pkg::STEP_W-1:0] step,
	output logic                         last
);

	import mant_pkg::*;

	logic [STEP_W-1:0] step_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			step_q <= '0;
		end else if (clear) begin
			step_q <= '0;                  // Clear wins over en
		end else if (en) begin
			step_q <= step_q + 1'b1;       // Wraps back to zero after the last step
		end
	end

	assign step = step_q;
	assign last = (step_q == STEP_W'(N_STEPS - 1));

endmodule

`default_nettype wire

//--- verif/mant_unit_props.sv
/* Handshake and reset checks for the mantissa unit, bound onto its top level.
   Reports only through failing assertions. */

`timescale 1ns/100ps
`default_nettype none

module mant_unit_props (
	input wire             clk,
	input wire             arst_n,
	input wire             req,
	input wire             ack,
	input mant_pkg::prod_t result
);

	import mant_pkg::*;

	//**********************************************************
	// Reset state
	//**********************************************************
	a_reset_state: assert property (@(posedge clk)
		$rose(arst_n) |-> (!ack && result == prod_t'(0)))
		else $error("ack or result not cleared by reset");

	//**********************************************************
	// Four-phase handshake
	//**********************************************************
	// ack may only rise on an edge that saw req high
	a_ack_rise: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(ack) |-> $past(req))
		else $error("ack rose without req");

	a_ack_fall: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(ack) |-> $past(!req))
		else $error("ack fell while req was still high");

	// Result frozen for the whole ack phase
	a_result_stable: assert property (@(posedge clk) disable iff (!arst_n)
		ack |-> $stable(result))
		else $error("result changed while ack was high");

endmodule

bind mant_unit_top mant_unit_props u_mant_unit_props (
	.clk    (clk),
	.arst_n (arst_n),
	.req    (req),
	.ack    (ack),
	.result (result)
);

`default_nettype wire

//--- verif/mant_unit_tb.sv
/* Testbench for the mantissa unit. Random multiply, add and subtract requests
   over the req/ack handshake, checked against a behavioral model. */

`timescale 1ns/100ps
`default_nettype none

module mant_unit_tb;

	import mant_pkg::*;

	localparam int CLK_PERIOD   = 10;
	localparam int RESET_CYCLES = 8;
	localparam int ACK_LIMIT    = 20;   // Cycles to wait for ack or its release
	localparam int N_MUL        = 300;
	localparam int N_ADD        = 150;
	localparam int N_SUB        = 150;
	localparam int N_CORNER     = 7;
	localparam int N_HS         = 12;
	localparam int N_OPS        = N_MUL + N_ADD + N_SUB + N_CORNER + N_HS;

	logic  clk;
	logic  arst_n;
	logic  req;
	op_e   op;
	opnd_t a;
	opnd_t b;
	logic  ack;
	prod_t result;
	logic  result_sign;

	int err_result;
	int err_sign;
	int err_hs;

	mant_unit_top u_mant_unit_top (
		.clk         (clk),
		.arst_n      (arst_n),
		.req         (req),
		.op          (op),
		.a           (a),
		.b           (b),
		.ack         (ack),
		.result      (result),
		.result_sign (result_sign)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//**********************************************************
	// Reference model and compare tasks
	//**********************************************************
	function automatic void model(input op_e op_in, input opnd_t a_in, input opnd_t b_in,
	                              output prod_t exp_res, output logic exp_sgn);
		int va;
		int vb;
		int s;
		if (op_in == OP_MUL) begin
			exp_res = prod_t'(a_in[MANT_W-1:0]) * prod_t'(b_in[MANT_W-1:0]);
			exp_sgn = 1'b0;
		end else begin
			va = int'($signed(a_in));
			vb = int'($signed(b_in));
			s  = (op_in == OP_SUB) ? va - vb : va + vb;
			exp_sgn = (s < 0);
			exp_res = prod_t'((s < 0) ? -s : s);
		end
	endfunction

	task automatic check_result(input string name, input prod_t exp, input prod_t act);
		if (exp !== act) begin
			$display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
			err_result++;
		end
	endtask

	task automatic check_sign(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("FAIL %0t %s expected %b got %b", $time, name, exp, act);
			err_sign++;
		end
	endtask

	// Occasionally hand out the extreme operand values
	function automatic opnd_t rand_opnd();
		int unsigned pick;
		pick = $urandom_range(0, 7);
		case (pick)
			0: return 25'h1000000;          // Most negative
			1: return 25'h0FFFFFF;          // Most positive
			default: return opnd_t'($urandom());
		endcase
	endfunction

	//**********************************************************
	// Four-phase exchange
	//**********************************************************
	task automatic exchange(input op_e op_in, input opnd_t a_in, input opnd_t b_in,
	                        input int hold, input prod_t exp_res, input logic exp_sgn);
		int waited;
		bit got_ack;
		@(posedge clk);
		#1;
		op  = op_in;
		a   = a_in;
		b   = b_in;
		req = 1'b1;
		waited  = 0;
		got_ack = 1'b0;
		while (!got_ack && waited < ACK_LIMIT) begin
			@(posedge clk);
			#1;
			waited++;
			got_ack = ack;
		end
		if (!got_ack) begin
			$display("Error at %0t: no ack within %0d cycles of req", $time, ACK_LIMIT);
			err_hs++;
		end else begin
			check_result("result", exp_res, result);
			check_sign("result_sign", exp_sgn, result_sign);
			repeat (hold) begin             // Requester keeps req high a while
				@(posedge clk);
				#1;
				if (!ack) begin
					$display("Error at %0t: ack dropped while req was high", $time);
					err_hs++;
				end
				check_result("result (held)", exp_res, result);
				check_sign("result_sign (held)", exp_sgn, result_sign);
			end
		end
		req = 1'b0;
		@(posedge clk);
		#1;
		if (ack) begin
			$display("Error at %0t: ack still high one cycle after req fell", $time);
			err_hs++;
		end
	endtask

	task automatic run_op(input op_e op_in, input opnd_t a_in, input opnd_t b_in,
	                      input int hold);
		prod_t exp_res;
		logic  exp_sgn;
		model(op_in, a_in, b_in, exp_res, exp_sgn);
		exchange(op_in, a_in, b_in, hold, exp_res, exp_sgn);
	endtask

	//**********************************************************
	// Main sequence
	//**********************************************************
	initial begin
		opnd_t x;
		err_result = 0;
		err_sign   = 0;
		err_hs     = 0;
		void'($urandom(60));
		arst_n = 1'b0;
		req    = 1'b0;
		op     = OP_MUL;
		a      = '0;
		b      = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		arst_n = 1'b1;
		if (ack) begin
			$display("Error at %0t: ack high after reset", $time);
			err_hs++;
		end
		check_result("result after reset", '0, result);
		check_sign("result_sign after reset", 1'b0, result_sign);

		for (int i = 0; i < N_MUL; i++) begin
			run_op(OP_MUL, opnd_t'($urandom()), opnd_t'($urandom()), $urandom_range(0, 3));
		end
		for (int i = 0; i < N_ADD; i++) begin
			run_op(OP_ADD, rand_opnd(), rand_opnd(), $urandom_range(0, 3));
		end
		for (int i = 0; i < N_SUB; i++) begin
			run_op(OP_SUB, rand_opnd(), rand_opnd(), $urandom_range(0, 3));
		end

		// Corner cases
		run_op(OP_MUL, 25'h1FFFFFF, 25'h1FFFFFF, 0);  // All-ones mantissas
		run_op(OP_MUL, '0, opnd_t'($urandom()), 0);
		run_op(OP_MUL, opnd_t'($urandom()), '0, 1);
		x = opnd_t'($urandom());
		run_op(OP_SUB, x, x, 0);                      // Zero magnitude, positive
		run_op(OP_SUB, 25'h0FFFFFF, 25'h1000000, 0);  // 2^25 - 1
		run_op(OP_SUB, 25'h1000000, 25'h0FFFFFF, 0);
		run_op(OP_ADD, 25'h1000000, 25'h1000000, 0);  // -2^25 uses bit 25

		// Long held req, then a fresh request must still be served
		for (int i = 0; i < N_HS; i++) begin
			run_op(op_e'($urandom_range(0, 2)), rand_opnd(), rand_opnd(),
			       $urandom_range(5, 15));
		end

		$display("Errors: result %0d, sign %0d, handshake %0d", err_result, err_sign, err_hs);
		if (err_result + err_sign + err_hs == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(CLK_PERIOD * (N_OPS * 20 + RESET_CYCLES));
		$display("Timeout: run did not finish within %0d operations worth of cycles", N_OPS);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
